// ==== include/llc_decode_params.svh ====
// address field widths and decision FIFO depth for the LLC
// input decode front end

`ifndef LLC_DECODE_PARAMS_SVH
`define LLC_DECODE_PARAMS_SVH

// set index and tag widths of a line address
`define LLC_SET_BITS 6
`define LLC_TAG_BITS 10

// tag sits above the set in a line address
`define LINE_ADDR_BITS (`LLC_SET_BITS + `LLC_TAG_BITS)

// default depth of the decision FIFO
`define DECODE_FIFO_DEPTH 2

`endif

// ==== source/llc_decode_pkg.sv ====
// address types, decode kind enum and the decode item carried
// through the decision FIFO

`include "llc_decode_params.svh"

package llc_decode_pkg;

    // set index of a line
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    // tag of a line
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    // line address, tag in the upper bits and set in the lower bits
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

    // which input channel an item came from
    typedef enum logic [1:0] {
        KIND_RESET   = 2'd0,
        KIND_RSP     = 2'd1,
        KIND_REQ     = 2'd2,
        KIND_DMA_REQ = 2'd3
    } decode_kind_e;

    // one arbiter decision
    // replays travel as KIND_REQ with the captured address
    typedef struct packed {
        decode_kind_e kind;
        line_addr_t   addr;
    } decode_item_t;

endpackage

// ==== source/llc_input_arbiter.sv ====
// fixed priority selection over the reset, response, replay, request
// and DMA request sources, with ready generation and decode item build

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_input_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        llc_reset_valid,
    input  logic                        rsp_in_valid,
    input  logic                        req_in_valid,
    input  logic                        dma_req_in_valid,
    input  llc_decode_pkg::line_addr_t  rsp_in_addr,
    input  llc_decode_pkg::line_addr_t  req_in_addr,
    input  llc_decode_pkg::line_addr_t  dma_req_in_addr,
    input  logic                        fifo_full,
    input  logic                        blocked,
    input  logic                        replay_valid,
    input  llc_decode_pkg::line_addr_t  replay_addr,
    output logic                        llc_reset_ready,
    output logic                        rsp_in_ready,
    output logic                        req_in_ready,
    output logic                        dma_req_in_ready,
    output logic                        replay_take,
    output logic                        push,
    output llc_decode_pkg::decode_item_t push_item
);

    logic arb_en;
    logic can_grant;

    // readys stay low for the first cycle out of reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            arb_en <= 1'b0;
        end else begin
            arb_en <= 1'b1;
        end
    end

    assign can_grant = arb_en && !fifo_full;

    always_comb begin
        llc_reset_ready  = 1'b0;
        rsp_in_ready     = 1'b0;
        req_in_ready     = 1'b0;
        dma_req_in_ready = 1'b0;
        replay_take      = 1'b0;
        push_item.kind   = llc_decode_pkg::KIND_RESET;
        push_item.addr   = {`LINE_ADDR_BITS{1'b0}};

        if (can_grant) begin
            if (llc_reset_valid) begin
                // reset has no address, zero is carried
                llc_reset_ready = 1'b1;
            end else if (rsp_in_valid) begin
                rsp_in_ready   = 1'b1;
                push_item.kind = llc_decode_pkg::KIND_RSP;
                push_item.addr = rsp_in_addr;
            end else if (replay_valid) begin
                // stalled request goes ahead of any new request
                replay_take    = 1'b1;
                push_item.kind = llc_decode_pkg::KIND_REQ;
                push_item.addr = replay_addr;
            end else if (req_in_valid && !blocked) begin
                req_in_ready   = 1'b1;
                push_item.kind = llc_decode_pkg::KIND_REQ;
                push_item.addr = req_in_addr;
            end else if (dma_req_in_valid && !blocked) begin
                dma_req_in_ready = 1'b1;
                push_item.kind   = llc_decode_pkg::KIND_DMA_REQ;
                push_item.addr   = dma_req_in_addr;
            end
        end
    end

    assign push = llc_reset_ready | rsp_in_ready | replay_take |
                  req_in_ready | dma_req_in_ready;

endmodule

// ==== source/llc_decode_fifo.sv ====
// decision FIFO holding decode items between the arbiter and the
// output stage

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_decode_fifo #(
    parameter int DEPTH = `DECODE_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  llc_decode_pkg::decode_item_t push_item,
    input  logic                         pop,
    output logic                         full,
    output logic                         not_empty,
    output llc_decode_pkg::decode_item_t head_item
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    llc_decode_pkg::decode_item_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full      = (count == CNT_BITS'(DEPTH));
    assign not_empty = (count != '0);
    assign head_item = mem[rd_ptr];

endmodule

// ==== source/llc_req_stall_tracker.sv ====
// request stall FSM with stalled line capture, response match clear
// and replay source for the arbiter

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_req_stall_tracker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         done,
    input  llc_decode_pkg::decode_kind_e done_kind,
    input  llc_decode_pkg::llc_set_t     done_set,
    input  llc_decode_pkg::llc_tag_t     done_tag,
    input  logic                         req_stall,
    input  logic                         replay_take,
    output logic                         blocked,
    output logic                         stalled,
    output logic                         replay_valid,
    output llc_decode_pkg::line_addr_t   replay_addr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STALLED,
        ST_REPLAY
    } stall_state_e;

    stall_state_e state;
    stall_state_e state_next;

    llc_decode_pkg::llc_set_t stall_set;
    llc_decode_pkg::llc_tag_t stall_tag;

    logic capture;
    logic rsp_match;

    // stall only counts when the request itself leaves the stage
    assign capture = (state == ST_IDLE) && done && req_stall &&
                     (done_kind == llc_decode_pkg::KIND_REQ);

    assign rsp_match = done && (done_kind == llc_decode_pkg::KIND_RSP) &&
                       (done_set == stall_set) && (done_tag == stall_tag);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (capture) begin
                    state_next = ST_STALLED;
                end
            end
            ST_STALLED: begin
                if (rsp_match) begin
                    state_next = ST_REPLAY;
                end
            end
            ST_REPLAY: begin
                if (replay_take) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // line of the stalled request
    always_ff @(posedge clk) begin
        if (capture) begin
            stall_set <= done_set;
            stall_tag <= done_tag;
        end
    end

    // new requests wait until the replay has been issued
    assign blocked      = (state != ST_IDLE);
    assign stalled      = (state == ST_STALLED);
    assign replay_valid = (state == ST_REPLAY);
    assign replay_addr  = {stall_tag, stall_set};

endmodule

// ==== source/llc_line_split.sv ====
// output register stage, loads from the FIFO head and splits the
// line address into set and tag

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_line_split (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         not_empty,
    input  llc_decode_pkg::decode_item_t head_item,
    input  logic                         out_ready,
    output logic                         pop,
    output logic                         out_valid,
    output llc_decode_pkg::decode_kind_e out_kind,
    output llc_decode_pkg::llc_set_t     out_set,
    output llc_decode_pkg::llc_tag_t     out_tag,
    output logic                         done,
    output llc_decode_pkg::decode_kind_e done_kind,
    output llc_decode_pkg::llc_set_t     done_set,
    output llc_decode_pkg::llc_tag_t     done_tag
);

    // take the next item when the register is empty or draining
    assign pop = not_empty && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload, held while the output is stalled
    always_ff @(posedge clk) begin
        if (pop) begin
            out_kind <= head_item.kind;
            out_tag  <= head_item.addr[`LINE_ADDR_BITS-1:`LLC_SET_BITS];
            out_set  <= head_item.addr[`LLC_SET_BITS-1:0];
        end
    end

    // completed output transfer, seen by the stall tracker
    assign done      = out_valid && out_ready;
    assign done_kind = out_kind;
    assign done_set  = out_set;
    assign done_tag  = out_tag;

endmodule

// ==== source/llc_decode_top.sv ====
// LLC input decode front end: arbiter, decision FIFO, output split
// stage and request stall tracker

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_decode_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         llc_reset_valid,
    output logic                         llc_reset_ready,
    input  logic                         rsp_in_valid,
    output logic                         rsp_in_ready,
    input  llc_decode_pkg::line_addr_t   rsp_in_addr,
    input  logic                         req_in_valid,
    output logic                         req_in_ready,
    input  llc_decode_pkg::line_addr_t   req_in_addr,
    input  logic                         dma_req_in_valid,
    output logic                         dma_req_in_ready,
    input  llc_decode_pkg::line_addr_t   dma_req_in_addr,
    output logic                         out_valid,
    input  logic                         out_ready,
    output llc_decode_pkg::decode_kind_e out_kind,
    output llc_decode_pkg::llc_set_t     out_set,
    output llc_decode_pkg::llc_tag_t     out_tag,
    input  logic                         req_stall,
    output logic                         stalled
);

    logic                         push;
    llc_decode_pkg::decode_item_t push_item;
    logic                         fifo_full;
    logic                         not_empty;
    llc_decode_pkg::decode_item_t head_item;
    logic                         pop;
    logic                         blocked;
    logic                         replay_valid;
    llc_decode_pkg::line_addr_t   replay_addr;
    logic                         replay_take;
    logic                         done;
    llc_decode_pkg::decode_kind_e done_kind;
    llc_decode_pkg::llc_set_t     done_set;
    llc_decode_pkg::llc_tag_t     done_tag;

    llc_input_arbiter i_arbiter (
        .clk              (clk),
        .rst              (rst),
        .llc_reset_valid  (llc_reset_valid),
        .rsp_in_valid     (rsp_in_valid),
        .req_in_valid     (req_in_valid),
        .dma_req_in_valid (dma_req_in_valid),
        .rsp_in_addr      (rsp_in_addr),
        .req_in_addr      (req_in_addr),
        .dma_req_in_addr  (dma_req_in_addr),
        .fifo_full        (fifo_full),
        .blocked          (blocked),
        .replay_valid     (replay_valid),
        .replay_addr      (replay_addr),
        .llc_reset_ready  (llc_reset_ready),
        .rsp_in_ready     (rsp_in_ready),
        .req_in_ready     (req_in_ready),
        .dma_req_in_ready (dma_req_in_ready),
        .replay_take      (replay_take),
        .push             (push),
        .push_item        (push_item)
    );

    llc_decode_fifo #(
        .DEPTH (`DECODE_FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .full      (fifo_full),
        .not_empty (not_empty),
        .head_item (head_item)
    );

    llc_line_split i_line_split (
        .clk       (clk),
        .rst       (rst),
        .not_empty (not_empty),
        .head_item (head_item),
        .out_ready (out_ready),
        .pop       (pop),
        .out_valid (out_valid),
        .out_kind  (out_kind),
        .out_set   (out_set),
        .out_tag   (out_tag),
        .done      (done),
        .done_kind (done_kind),
        .done_set  (done_set),
        .done_tag  (done_tag)
    );

    llc_req_stall_tracker i_stall_tracker (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .done_kind    (done_kind),
        .done_set     (done_set),
        .done_tag     (done_tag),
        .req_stall    (req_stall),
        .replay_take  (replay_take),
        .blocked      (blocked),
        .stalled      (stalled),
        .replay_valid (replay_valid),
        .replay_addr  (replay_addr)
    );

endmodule

// ==== testbench/llc_decode_assert.sv ====
// bound checks for the LLC decode front end with an expected item ring,
// a reference stall model and the concurrent assertions over both

`timescale 1ns/10ps
`include "llc_decode_params.svh"

module llc_decode_assert (
    input logic                         clk,
    input logic                         rst,
    input logic                         llc_reset_valid,
    input logic                         llc_reset_ready,
    input logic                         rsp_in_valid,
    input logic                         rsp_in_ready,
    input llc_decode_pkg::line_addr_t   rsp_in_addr,
    input logic                         req_in_valid,
    input logic                         req_in_ready,
    input llc_decode_pkg::line_addr_t   req_in_addr,
    input logic                         dma_req_in_valid,
    input logic                         dma_req_in_ready,
    input llc_decode_pkg::line_addr_t   dma_req_in_addr,
    input logic                         out_valid,
    input logic                         out_ready,
    input llc_decode_pkg::decode_kind_e out_kind,
    input llc_decode_pkg::llc_set_t     out_set,
    input llc_decode_pkg::llc_tag_t     out_tag,
    input logic                         req_stall,
    input logic                         stalled,
    input logic                         fifo_full,
    input logic                         replay_take,
    input llc_decode_pkg::line_addr_t   replay_addr
);

    localparam int EXP_DEPTH = 8;

    typedef enum logic [1:0] {
        M_IDLE,
        M_STALLED,
        M_REPLAY
    } model_state_e;

    logic                         failed = 1'b0;
    logic                         arb_live;
    logic                         acc;
    logic                         out_xfer;
    logic                         stall_hit;
    logic [4:0]                   ready_vec;
    logic [2:0]                   exp_wr;
    logic [2:0]                   exp_rd;
    logic [3:0]                   exp_count;
    llc_decode_pkg::decode_item_t exp_mem [EXP_DEPTH];
    llc_decode_pkg::decode_item_t acc_item;
    llc_decode_pkg::decode_item_t exp_head;
    model_state_e                 model_state;
    llc_decode_pkg::llc_set_t     cap_set;
    llc_decode_pkg::llc_tag_t     cap_tag;

    assign ready_vec = {llc_reset_ready, rsp_in_ready, replay_take, req_in_ready,
                        dma_req_in_ready};
    assign out_xfer  = out_valid && out_ready;
    assign exp_head  = exp_mem[exp_rd];
    assign stall_hit = (model_state == M_IDLE) && out_xfer && req_stall &&
                       (out_kind == llc_decode_pkg::KIND_REQ);

    // item accepted this cycle
    // a replay carries the line from the model's own capture
    always_comb begin
        acc           = 1'b1;
        acc_item.kind = llc_decode_pkg::KIND_RESET;
        acc_item.addr = '0;
        if (llc_reset_valid && llc_reset_ready) begin
            acc_item.kind = llc_decode_pkg::KIND_RESET;
        end else if (rsp_in_valid && rsp_in_ready) begin
            acc_item.kind = llc_decode_pkg::KIND_RSP;
            acc_item.addr = rsp_in_addr;
        end else if (replay_take) begin
            acc_item.kind = llc_decode_pkg::KIND_REQ;
            acc_item.addr = {cap_tag, cap_set};
        end else if (req_in_valid && req_in_ready) begin
            acc_item.kind = llc_decode_pkg::KIND_REQ;
            acc_item.addr = req_in_addr;
        end else if (dma_req_in_valid && dma_req_in_ready) begin
            acc_item.kind = llc_decode_pkg::KIND_DMA_REQ;
            acc_item.addr = dma_req_in_addr;
        end else begin
            acc = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            exp_mem[exp_wr] <= acc_item;
        end
        if (stall_hit) begin
            cap_set <= out_set;
            cap_tag <= out_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            arb_live    <= 1'b0;
            exp_wr      <= '0;
            exp_rd      <= '0;
            exp_count   <= '0;
            model_state <= M_IDLE;
        end else begin
            arb_live  <= 1'b1;
            exp_wr    <= exp_wr + 3'(acc);
            exp_rd    <= exp_rd + 3'(out_xfer);
            exp_count <= exp_count + 4'(acc) - 4'(out_xfer);
            case (model_state)
                M_IDLE: begin
                    if (stall_hit) begin
                        model_state <= M_STALLED;
                    end
                end
                M_STALLED: begin
                    if (out_xfer && out_kind == llc_decode_pkg::KIND_RSP &&
                        out_set == cap_set && out_tag == cap_tag) begin
                        model_state <= M_REPLAY;
                    end
                end
                M_REPLAY: begin
                    if (replay_take) begin
                        model_state <= M_IDLE;
                    end
                end
                default: begin
                    model_state <= M_IDLE;
                end
            endcase
        end
    end

    // reset and first cycle after it
    a_reset_state: assert property (@(posedge clk)
        !arb_live |-> !out_valid && !stalled && ready_vec == '0)
        else begin
            $error("Fail %0t: output or ready high around reset", $time);
            failed = 1'b1;
        end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(ready_vec) && (!fifo_full || ready_vec == '0))
        else begin
            $error("Fail %0t: bad grant count or grant while full", $time);
            failed = 1'b1;
        end

    a_prio_reset: assert property (@(posedge clk) disable iff (!rst)
        arb_live && !fifo_full && llc_reset_valid |-> llc_reset_ready)
        else begin
            $error("Fail %0t: reset request not granted", $time);
            failed = 1'b1;
        end

    a_prio_rsp: assert property (@(posedge clk) disable iff (!rst)
        arb_live && !fifo_full && rsp_in_valid && !llc_reset_valid |-> rsp_in_ready)
        else begin
            $error("Fail %0t: response not granted", $time);
            failed = 1'b1;
        end

    a_prio_req: assert property (@(posedge clk) disable iff (!rst)
        arb_live && !fifo_full && req_in_valid && !llc_reset_valid && !rsp_in_valid &&
        model_state == M_IDLE |-> req_in_ready)
        else begin
            $error("Fail %0t: request not granted", $time);
            failed = 1'b1;
        end

    a_blocked: assert property (@(posedge clk) disable iff (!rst)
        model_state != M_IDLE |-> !req_in_ready && !dma_req_in_ready)
        else begin
            $error("Fail %0t: new request taken during stall", $time);
            failed = 1'b1;
        end

    a_stalled: assert property (@(posedge clk) disable iff (!rst)
        stalled == (model_state == M_STALLED))
        else begin
            $error("Fail %0t: stalled differs from stall model", $time);
            failed = 1'b1;
        end

    a_replay: assert property (@(posedge clk) disable iff (!rst)
        replay_take |-> model_state == M_REPLAY && replay_addr == {cap_tag, cap_set})
        else begin
            $error("Fail %0t: replay early or with wrong line", $time);
            failed = 1'b1;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_kind) && $stable(out_set) &&
        $stable(out_tag))
        else begin
            $error("Fail %0t: output changed under back-pressure", $time);
            failed = 1'b1;
        end

    a_order: assert property (@(posedge clk) disable iff (!rst)
        out_xfer |-> exp_count != '0 && out_kind == exp_head.kind &&
        out_set == exp_head.addr[`LLC_SET_BITS-1:0] &&
        out_tag == exp_head.addr[`LINE_ADDR_BITS-1:`LLC_SET_BITS] &&
        (out_kind != llc_decode_pkg::KIND_RESET || (out_set == '0 && out_tag == '0)))
        else begin
            $error("Fail %0t: output item differs from expected", $time);
            failed = 1'b1;
        end

endmodule

bind llc_decode_top llc_decode_assert i_assert (.*);

// ==== testbench/tb_llc_decode_top.sv ====
// testbench for the LLC decode front end with clock, reset, random
// valid/ready stimulus, watchdog and end of run report

`timescale 1ns/10ps

module tb_llc_decode_top;

    localparam int CLK_PERIOD   = 4;
    localparam int STIM_CYCLES  = 3000;
    localparam int DRAIN_MARGIN = 300;

    logic                         clk;
    logic                         rst;
    logic                         llc_reset_valid;
    logic                         llc_reset_ready;
    logic                         rsp_in_valid;
    logic                         rsp_in_ready;
    llc_decode_pkg::line_addr_t   rsp_in_addr;
    logic                         req_in_valid;
    logic                         req_in_ready;
    llc_decode_pkg::line_addr_t   req_in_addr;
    logic                         dma_req_in_valid;
    logic                         dma_req_in_ready;
    llc_decode_pkg::line_addr_t   dma_req_in_addr;
    logic                         out_valid;
    logic                         out_ready;
    llc_decode_pkg::decode_kind_e out_kind;
    llc_decode_pkg::llc_set_t     out_set;
    llc_decode_pkg::llc_tag_t     out_tag;
    logic                         req_stall;
    logic                         stalled;
    int unsigned                  seed_value;

    llc_decode_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // small pool of lines so that responses hit stalled requests
    function automatic llc_decode_pkg::line_addr_t pick_line_addr();
        llc_decode_pkg::llc_tag_t line_tag;
        llc_decode_pkg::llc_set_t line_set;
        line_tag = ($urandom_range(0, 1) == 0) ? 'h005 : 'h3a0;
        line_set = ($urandom_range(0, 1) == 0) ? 'h11 : 'h2c;
        return {line_tag, line_set};
    endfunction

    // one clock of stimulus with valids held until their transfer
    task automatic drive_cycle(input bit fresh, input bit hold_out);
        bit reset_done;
        bit rsp_done;
        bit req_done;
        bit dma_done;
        @(negedge clk);
        reset_done = llc_reset_valid && llc_reset_ready;
        rsp_done   = rsp_in_valid && rsp_in_ready;
        req_done   = req_in_valid && req_in_ready;
        dma_done   = dma_req_in_valid && dma_req_in_ready;
        @(posedge clk);
        #1;
        if (!llc_reset_valid || reset_done) begin
            llc_reset_valid = fresh && ($urandom_range(0, 31) == 0);
        end
        if (!rsp_in_valid || rsp_done) begin
            rsp_in_valid = fresh && ($urandom_range(0, 2) == 0);
            rsp_in_addr  = pick_line_addr();
        end
        if (!req_in_valid || req_done) begin
            req_in_valid = fresh && ($urandom_range(0, 1) == 0);
            req_in_addr  = pick_line_addr();
        end
        if (!dma_req_in_valid || dma_done) begin
            dma_req_in_valid = fresh && ($urandom_range(0, 2) == 0);
            dma_req_in_addr  = pick_line_addr();
        end
        out_ready = !hold_out && (!fresh || $urandom_range(0, 3) != 0);
        req_stall = fresh && out_valid && (out_kind == llc_decode_pkg::KIND_REQ) &&
                    ($urandom_range(0, 2) == 0);
    endtask

    // a failing assertion ends the run at once
    initial begin
        @(posedge i_dut.i_assert.failed);
        $display("TEST FAIL");
        $fatal(1, "an assertion check failed");
    end

    initial begin
        #((STIM_CYCLES + DRAIN_MARGIN) * CLK_PERIOD);
        $display("TEST FAIL");
        $fatal(1, "timeout: the run did not finish in time");
    end

    initial begin
        seed_value       = $urandom(32'ha8ba9c7c);
        rst              = 1'b0;
        llc_reset_valid  = 1'b0;
        rsp_in_valid     = 1'b0;
        rsp_in_addr      = '0;
        req_in_valid     = 1'b0;
        req_in_addr      = '0;
        dma_req_in_valid = 1'b0;
        dma_req_in_addr  = '0;
        out_ready        = 1'b0;
        req_stall        = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b1;

        // random traffic with a short output stall every 200 cycles
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            drive_cycle(1'b1, (cyc % 200) < 6);
        end

        // finish held transfers and empty the pipeline
        drive_cycle(1'b0, 1'b0);
        while (llc_reset_valid || rsp_in_valid || out_valid || i_dut.not_empty ||
               i_dut.replay_valid || (!stalled && (req_in_valid || dma_req_in_valid))) begin
            drive_cycle(1'b0, 1'b0);
        end
        repeat (2) @(posedge clk);
        #1;

        if (i_dut.i_assert.failed) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion check failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+include
source/llc_decode_pkg.sv
source/llc_input_arbiter.sv
source/llc_decode_fifo.sv
source/llc_req_stall_tracker.sv
source/llc_line_split.sv
source/llc_decode_top.sv
testbench/llc_decode_assert.sv
testbench/tb_llc_decode_top.sv

// ==== Bender.yml ====
package:
  name: llc_decode

sources:
  - include_dirs:
      - include
    files:
      - source/llc_decode_pkg.sv
      - source/llc_input_arbiter.sv
      - source/llc_decode_fifo.sv
      - source/llc_req_stall_tracker.sv
      - source/llc_line_split.sv
      - source/llc_decode_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/llc_decode_assert.sv
      - testbench/tb_llc_decode_top.sv
